/* Bender.yml */
package:
  name: autotest

sources:
  - logic/autotest_pkg.sv
  - logic/sd_pkg.sv
  - logic/record_loader.sv
  - logic/uut_runner.sv
  - logic/report_writer.sv
  - logic/test_sequencer.sv
  - logic/autotest_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_checker.sv
      - tests/autotest_assert.sv
      - tests/tb_top.sv

/* list.f */
logic/autotest_pkg.sv
logic/sd_pkg.sv
logic/record_loader.sv
logic/uut_runner.sv
logic/report_writer.sv
logic/test_sequencer.sv
logic/autotest_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/autotest_assert.sv
tests/tb_top.sv

/* logic/autotest_pkg.sv */
/*
  Test record and failure report definitions for the self-test sequencer.
  A record is the first 16 bytes of an SD block, captured byte by byte
  and read back by field. Operand and expected words arrive least
  significant byte first, so their fields hold the bytes in arrival order
  and swap_bytes() turns them into numeric values.
*/
package autotest_pkg;

  typedef logic [31:0] operand_t;
  typedef logic [31:0] result_t;
  typedef logic [63:0] exec_time_t;
  typedef logic [31:0] error_count_t;

  localparam logic [31:0] SIGNATURE = 32'hAABBCCDD;
  localparam int RECORD_BYTES = 16;
  localparam int REPORT_BYTES = 28;
  localparam logic [7:0] FILL_BYTE = 8'hFF;

  // byte 0 sits in the top bits, same as element 0 of the byte view
  typedef struct packed {
    logic [31:0] signature;
    operand_t    operand_a;
    operand_t    operand_b;
    result_t     expected;
  } record_fields_t;

  typedef union packed {
    logic [0:RECORD_BYTES-1][7:0] bytes;
    record_fields_t               fields;
  } record_u;

  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

/* logic/autotest_top.sv */
/*
  Self-test top level. Connects the sequencer to the record loader, the
  UUT runner and the report serializer. The SPI host and the UUT sit
  outside this block.
*/
`timescale 1ns/10ps

module autotest_top (
  input  logic                       clk,
  input  logic                       rst,
  input  sd_pkg::spi_stat_t          spi_stat_i,
  input  logic                       end_uut_i,
  input  autotest_pkg::result_t      result_i,
  output sd_pkg::spi_cmd_t           spi_cmd_o,
  output sd_pkg::block_addr_t        spi_block_addr_o,
  output logic [7:0]                 spi_data_in_o,
  output logic                       uut_rst_o,
  output autotest_pkg::operand_t     operand_a_o,
  output autotest_pkg::operand_t     operand_b_o,
  output autotest_pkg::error_count_t error_count_o,
  output logic                       done_o
);

  logic                     load_we;
  sd_pkg::byte_idx_t        byte_idx;
  autotest_pkg::record_u    record;
  logic                     run_start;
  logic                     uut_done;
  logic                     mismatch;
  autotest_pkg::result_t    result;
  autotest_pkg::exec_time_t exec_time;
  logic [7:0]               report_byte;

  test_sequencer u_seq (
    .clk(clk), .rst(rst), .spi_stat_i(spi_stat_i), .record_i(record),
    .uut_done_i(uut_done), .mismatch_i(mismatch), .report_byte_i(report_byte),
    .spi_cmd_o(spi_cmd_o), .spi_block_addr_o(spi_block_addr_o),
    .spi_data_in_o(spi_data_in_o), .load_we_o(load_we), .byte_idx_o(byte_idx),
    .run_start_o(run_start), .done_o(done_o)
  );

  record_loader u_loader (
    .clk(clk), .rst(rst), .load_we_i(load_we), .byte_idx_i(byte_idx),
    .data_i(spi_stat_i.data_out), .record_o(record)
  );

  uut_runner u_runner (
    .clk(clk), .rst(rst), .run_start_i(run_start), .end_uut_i(end_uut_i),
    .result_i(result_i), .record_i(record), .uut_rst_o(uut_rst_o),
    .operand_a_o(operand_a_o), .operand_b_o(operand_b_o), .result_o(result),
    .exec_time_o(exec_time), .uut_done_o(uut_done), .mismatch_o(mismatch),
    .error_count_o(error_count_o)
  );

  report_writer u_report (
    .byte_idx_i(byte_idx), .record_i(record), .result_i(result),
    .exec_time_i(exec_time), .data_o(report_byte)
  );

endmodule

/* logic/record_loader.sv */
/*
  Test record capture. Bytes read from the SD block are stored by their
  position in the block; only the first RECORD_BYTES positions are kept,
  the rest of the block passes by unused.
*/
`timescale 1ns/10ps

module record_loader (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load_we_i,
  input  sd_pkg::byte_idx_t     byte_idx_i,
  input  logic [7:0]            data_i,
  output autotest_pkg::record_u record_o
);

  logic in_record;

  assign in_record = (byte_idx_i < autotest_pkg::RECORD_BYTES);

  always_ff @(posedge clk) begin
    if (rst) begin
      record_o <= '0;
    end else if (load_we_i && in_record) begin
      // element k holds block byte k
      record_o.bytes[byte_idx_i[3:0]] <= data_i;
    end
  end

endmodule

/* logic/report_writer.sv */
/*
  Failure report serializer. Returns the report byte at the given block
  position: the record as read, then the captured result and the
  execution time, both least significant byte first, then fill bytes up
  to the end of the block.
*/
`timescale 1ns/10ps

module report_writer (
  input  sd_pkg::byte_idx_t        byte_idx_i,
  input  autotest_pkg::record_u    record_i,
  input  autotest_pkg::result_t    result_i,
  input  autotest_pkg::exec_time_t exec_time_i,
  output logic [7:0]               data_o
);

  localparam int RESULT_BASE = autotest_pkg::RECORD_BYTES;
  localparam int TIME_BASE   = RESULT_BASE + 4;

  sd_pkg::byte_idx_t res_off;
  sd_pkg::byte_idx_t time_off;

  assign res_off  = byte_idx_i - sd_pkg::byte_idx_t'(RESULT_BASE);
  assign time_off = byte_idx_i - sd_pkg::byte_idx_t'(TIME_BASE);

  always_comb begin
    if (byte_idx_i < RESULT_BASE) begin
      // signature goes out msb first, as stored
      data_o = record_i.bytes[byte_idx_i[3:0]];
    end else if (byte_idx_i < TIME_BASE) begin
      data_o = result_i[{res_off[1:0], 3'b000} +: 8];
    end else if (byte_idx_i < autotest_pkg::REPORT_BYTES) begin
      data_o = exec_time_i[{time_off[2:0], 3'b000} +: 8];
    end else begin
      data_o = autotest_pkg::FILL_BYTE;
    end
  end

endmodule

/* logic/sd_pkg.sv */
/*
  SD card block addressing and the SPI host command and status words.
  Command bits are held until the host raises busy; data_out is valid
  in the cycle busy falls after a byte read.
*/
package sd_pkg;

  localparam int BLOCK_BYTES = 512;
  localparam logic [31:0] START_BLOCK = 32'h0010_0000;

  typedef logic [31:0] block_addr_t;
  typedef logic [9:0]  byte_idx_t;

  typedef struct packed {
    logic rst;
    logic r_block;
    logic r_byte;
    logic w_block;
    logic w_byte;
  } spi_cmd_t;

  typedef struct packed {
    logic       busy;
    logic [7:0] data_out;
  } spi_stat_t;

endpackage

/* logic/test_sequencer.sv */
/*
  Main FSM of the self-test session. Resets the SPI host, reads each test
  block in full, checks the signature, starts the UUT run and, on a
  mismatch, writes the failure report over the same block. Every command
  is held until the host raises busy, then the FSM waits for busy to fall.
  A block with a bad signature ends the session with done_o high.
*/
`timescale 1ns/10ps

module test_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  sd_pkg::spi_stat_t     spi_stat_i,
  input  autotest_pkg::record_u record_i,
  input  logic                  uut_done_i,
  input  logic                  mismatch_i,
  input  logic [7:0]            report_byte_i,
  output sd_pkg::spi_cmd_t      spi_cmd_o,
  output sd_pkg::block_addr_t   spi_block_addr_o,
  output logic [7:0]            spi_data_in_o,
  output logic                  load_we_o,
  output sd_pkg::byte_idx_t     byte_idx_o,
  output logic                  run_start_o,
  output logic                  done_o
);

  typedef enum logic [3:0] {
    ST_SPI_RST, ST_SPI_RST_WAIT, ST_IDLE,
    ST_RD_BLOCK, ST_RD_BLOCK_WAIT, ST_RD_BYTE, ST_RD_BYTE_WAIT,
    ST_CHECK, ST_RUN,
    ST_WR_BLOCK, ST_WR_BLOCK_WAIT, ST_WR_BYTE, ST_WR_BYTE_WAIT,
    ST_NEXT, ST_DONE
  } state_t;

  state_t state, state_nx;
  sd_pkg::block_addr_t block_addr;
  sd_pkg::byte_idx_t byte_cnt;
  logic [7:0] data_q;
  logic busy;
  logic cnt_clr;
  logic cnt_inc;
  logic blk_inc;

  assign busy = spi_stat_i.busy;

  always_comb begin
    state_nx    = state;
    spi_cmd_o   = '0;
    load_we_o   = 1'b0;
    run_start_o = 1'b0;
    cnt_clr     = 1'b0;
    cnt_inc     = 1'b0;
    blk_inc     = 1'b0;
    case (state)
      ST_SPI_RST: begin
        spi_cmd_o.rst = 1'b1;
        if (busy) state_nx = ST_SPI_RST_WAIT;
      end
      ST_SPI_RST_WAIT: if (!busy) state_nx = ST_IDLE;
      ST_IDLE: begin
        cnt_clr = 1'b1;
        if (!busy) state_nx = ST_RD_BLOCK;
      end
      ST_RD_BLOCK: begin
        spi_cmd_o.r_block = 1'b1;
        if (busy) state_nx = ST_RD_BLOCK_WAIT;
      end
      ST_RD_BLOCK_WAIT: begin
        spi_cmd_o.r_block = 1'b1;
        if (!busy) state_nx = ST_RD_BYTE;
      end
      ST_RD_BYTE: begin
        spi_cmd_o.r_block = 1'b1;
        spi_cmd_o.r_byte  = 1'b1;
        if (busy) state_nx = ST_RD_BYTE_WAIT;
      end
      ST_RD_BYTE_WAIT: begin
        spi_cmd_o.r_block = 1'b1;
        if (!busy) begin
          // data_out is only valid in this cycle
          load_we_o = 1'b1;
          cnt_inc   = 1'b1;
          if (byte_cnt == sd_pkg::byte_idx_t'(sd_pkg::BLOCK_BYTES - 1)) begin
            state_nx = ST_CHECK;
          end else begin
            state_nx = ST_RD_BYTE;
          end
        end
      end
      ST_CHECK: begin
        if (!busy) begin
          if (record_i.fields.signature == autotest_pkg::SIGNATURE) begin
            run_start_o = 1'b1;
            state_nx    = ST_RUN;
          end else begin
            state_nx = ST_DONE;
          end
        end
      end
      ST_RUN: begin
        cnt_clr = 1'b1;
        if (uut_done_i) state_nx = mismatch_i ? ST_WR_BLOCK : ST_NEXT;
      end
      ST_WR_BLOCK: begin
        spi_cmd_o.w_block = 1'b1;
        if (busy) state_nx = ST_WR_BLOCK_WAIT;
      end
      ST_WR_BLOCK_WAIT: begin
        spi_cmd_o.w_block = 1'b1;
        if (!busy) state_nx = ST_WR_BYTE;
      end
      ST_WR_BYTE: begin
        spi_cmd_o.w_block = 1'b1;
        spi_cmd_o.w_byte  = 1'b1;
        // count on accept so the next byte is fetched while busy
        if (busy) begin
          cnt_inc  = 1'b1;
          state_nx = ST_WR_BYTE_WAIT;
        end
      end
      ST_WR_BYTE_WAIT: begin
        spi_cmd_o.w_block = 1'b1;
        if (!busy) begin
          if (byte_cnt == sd_pkg::byte_idx_t'(sd_pkg::BLOCK_BYTES)) begin
            state_nx = ST_NEXT;
          end else begin
            state_nx = ST_WR_BYTE;
          end
        end
      end
      ST_NEXT: begin
        blk_inc  = 1'b1;
        state_nx = ST_IDLE;
      end
      ST_DONE: state_nx = ST_DONE;
      default: state_nx = ST_SPI_RST;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_SPI_RST;
      block_addr <= sd_pkg::START_BLOCK;
      byte_cnt   <= '0;
    end else begin
      state <= state_nx;
      if (blk_inc) block_addr <= block_addr + 32'd1;
      if (cnt_clr) begin
        byte_cnt <= '0;
      end else if (cnt_inc) begin
        byte_cnt <= byte_cnt + 10'd1;
      end
    end
  end

  // write byte stays stable while w_byte is up
  always_ff @(posedge clk) begin
    if (state == ST_WR_BLOCK_WAIT || state == ST_WR_BYTE_WAIT) begin
      data_q <= report_byte_i;
    end
  end

  assign spi_block_addr_o = block_addr;
  assign spi_data_in_o    = data_q;
  assign byte_idx_o       = byte_cnt;
  assign done_o           = (state == ST_DONE);

endmodule

/* logic/uut_runner.sv */
/*
  UUT run control. Releases the UUT from reset on run_start, counts the
  cycles until end_uut, then captures the result, compares it with the
  expected value of the record and pulses uut_done. The error counter
  keeps the number of failed tests for the whole session.
*/
`timescale 1ns/10ps

module uut_runner (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run_start_i,
  input  logic                       end_uut_i,
  input  autotest_pkg::result_t      result_i,
  input  autotest_pkg::record_u      record_i,
  output logic                       uut_rst_o,
  output autotest_pkg::operand_t     operand_a_o,
  output autotest_pkg::operand_t     operand_b_o,
  output autotest_pkg::result_t      result_o,
  output autotest_pkg::exec_time_t   exec_time_o,
  output logic                       uut_done_o,
  output logic                       mismatch_o,
  output autotest_pkg::error_count_t error_count_o
);

  autotest_pkg::result_t expected;
  logic running;
  logic fail;

  assign operand_a_o = autotest_pkg::swap_bytes(record_i.fields.operand_a);
  assign operand_b_o = autotest_pkg::swap_bytes(record_i.fields.operand_b);
  assign expected    = autotest_pkg::swap_bytes(record_i.fields.expected);

  assign running = ~uut_rst_o;
  assign fail    = (result_i != expected);

  always_ff @(posedge clk) begin
    if (rst) begin
      uut_rst_o     <= 1'b1;
      uut_done_o    <= 1'b0;
      error_count_o <= '0;
    end else begin
      uut_done_o <= 1'b0;
      if (run_start_i) begin
        uut_rst_o <= 1'b0;
      end else if (running && end_uut_i) begin
        // back into reset together with the done pulse
        uut_rst_o  <= 1'b1;
        uut_done_o <= 1'b1;
        if (fail) begin
          error_count_o <= error_count_o + 32'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run_start_i) begin
      exec_time_o <= '0;
    end else if (running) begin
      if (end_uut_i) begin
        result_o   <= result_i;
        mismatch_o <= fail;
      end else begin
        exec_time_o <= exec_time_o + 64'd1;
      end
    end
  end

endmodule

/* tests/autotest_assert.sv */
/*
  Concurrent assertions on the sequencer command outputs, bound into the
  self-test top level. fail_cnt counts failed assertions for the testbench.
*/
`timescale 1ns/10ps

module autotest_assert (
  input logic             clk,
  input logic             rst,
  input sd_pkg::spi_cmd_t spi_cmd_o,
  input logic             uut_rst_o,
  input logic             done_o
);

  int fail_cnt = 0;

  assert property (@(posedge clk) disable iff (rst)
    !((spi_cmd_o.r_block || spi_cmd_o.r_byte) && (spi_cmd_o.w_block || spi_cmd_o.w_byte)))
    else begin
      $error("read and write commands active together");
      fail_cnt++;
    end

  // UUT must be parked while the SPI host works
  assert property (@(posedge clk) disable iff (rst) (spi_cmd_o != '0) |-> uut_rst_o)
    else begin
      $error("SPI command active while UUT runs");
      fail_cnt++;
    end

  assert property (@(posedge clk) disable iff (rst) done_o |=> done_o)
    else begin
      $error("done fell before reset");
      fail_cnt++;
    end

endmodule

bind autotest_top autotest_assert sva0 (
  .clk(clk), .rst(rst), .spi_cmd_o(spi_cmd_o), .uut_rst_o(uut_rst_o), .done_o(done_o)
);

/* tests/tb_checker.sv */
/*
  Testbench checker. Watches the DUT outputs on the rising edge, builds
  the expected failure report from the test table and compares every
  written byte, the operands, the error counter and the block address.
  Prints one line per finished test and a closing count line.
*/
`timescale 1ns/10ps

module tb_checker (
  input  logic                       clk,
  input  logic                       rst,
  input  sd_pkg::spi_cmd_t           spi_cmd_i,
  input  sd_pkg::spi_stat_t          spi_stat_i,
  input  sd_pkg::block_addr_t        block_addr_i,
  input  logic [7:0]                 data_in_i,
  input  logic                       uut_rst_i,
  input  autotest_pkg::operand_t     operand_a_i,
  input  autotest_pkg::operand_t     operand_b_i,
  input  autotest_pkg::error_count_t error_count_i,
  input  logic                       done_i,
  input  logic [5:0][31:0]           op_a_i,
  input  logic [5:0][31:0]           op_b_i,
  input  logic [5:0][31:0]           expected_i,
  input  logic [5:0][7:0]            latency_i,
  output logic                       finished_o,
  output int                         errors_o
);

  int cur;
  int reads;
  int writes;
  int tests;
  int exp_err;
  int idle_cycles;
  logic first;
  logic done_seen;
  logic prev_done;
  sd_pkg::block_addr_t prev_addr;
  autotest_pkg::error_count_t prev_err;

  function automatic logic is_fail(input int blk);
    return (blk < 5) && (expected_i[blk] != op_a_i[blk] + op_b_i[blk]);
  endfunction

  // expected report byte, built from the record layout and the UUT model
  function automatic logic [7:0] report_byte(input int blk, input int idx);
    logic [31:0] sum;
    logic [63:0] t;
    sum = op_a_i[blk] + op_b_i[blk];
    t = 64'(latency_i[blk]);
    if (idx < 4) return 8'(autotest_pkg::SIGNATURE >> (8 * (3 - idx)));
    if (idx < 8) return 8'(op_a_i[blk] >> (8 * (idx - 4)));
    if (idx < 12) return 8'(op_b_i[blk] >> (8 * (idx - 8)));
    if (idx < 16) return 8'(expected_i[blk] >> (8 * (idx - 12)));
    if (idx < 20) return 8'(sum >> (8 * (idx - 16)));
    if (idx < 28) return 8'(t >> (8 * (idx - 20)));
    return 8'hFF;
  endfunction

  task automatic value_error(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
    errors_o++;
  endtask

  task automatic note_failure(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    errors_o++;
  endtask

  task automatic end_test(input int blk);
    int exp_wr;
    exp_wr = is_fail(blk) ? 512 : 0;
    if (reads != 512) value_error("read byte count", reads, 512);
    if (writes != exp_wr) value_error("write byte count", writes, exp_wr);
    $display("test %0d block %h: %s, %0d bytes read, %0d bytes written", tests,
             sd_pkg::START_BLOCK + blk, (blk == 5) ? "end marker" :
             (is_fail(blk) ? "failing" : "passing"), reads, writes);
    tests++;
    reads = 0;
    writes = 0;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      first = 1'b1;
      done_seen = 1'b0;
      prev_done = 1'b0;
      prev_addr = sd_pkg::START_BLOCK;
      prev_err = '0;
      reads = 0;
      writes = 0;
      tests = 0;
      exp_err = 0;
      idle_cycles = 0;
      finished_o = 1'b0;
    end else if (!finished_o) begin
      if (first) begin
        if (done_i) note_failure("done high right after reset");
        if (!uut_rst_i) note_failure("UUT not held in reset after reset");
        if (spi_cmd_i != 5'b10000) value_error("spi_cmd_o", spi_cmd_i, 5'b10000);
        first = 1'b0;
      end
      cur = int'(block_addr_i - sd_pkg::START_BLOCK);
      if (cur > 5) note_failure("block address beyond the last test block");
      if (spi_cmd_i.r_byte && spi_stat_i.busy) reads++;
      if (spi_cmd_i.w_byte && spi_stat_i.busy && cur <= 5) begin
        if (data_in_i != report_byte(cur, writes)) begin
          value_error("spi_data_in_o", data_in_i, report_byte(cur, writes));
        end
        writes++;
      end
      if (!uut_rst_i && cur <= 5) begin
        if (operand_a_i != op_a_i[cur]) value_error("operand_a_o", operand_a_i, op_a_i[cur]);
        if (operand_b_i != op_b_i[cur]) value_error("operand_b_o", operand_b_i, op_b_i[cur]);
      end
      if (error_count_i != prev_err) begin
        if (error_count_i != prev_err + 1) begin
          value_error("error_count_o", error_count_i, prev_err + 1);
        end
        if (!is_fail(cur)) note_failure("error counter moved on a passing test");
        prev_err = error_count_i;
      end
      if (block_addr_i != prev_addr) begin
        if (block_addr_i != prev_addr + 1) begin
          value_error("spi_block_addr_o", block_addr_i, prev_addr + 1);
        end
        if (is_fail(int'(prev_addr - sd_pkg::START_BLOCK))) exp_err++;
        end_test(int'(prev_addr - sd_pkg::START_BLOCK));
        if (error_count_i != exp_err) value_error("error_count_o", error_count_i, exp_err);
        prev_addr = block_addr_i;
      end
      if (prev_done && !done_i) note_failure("done fell before reset");
      if (done_seen && spi_cmd_i != '0) note_failure("SPI command issued after done");
      if (done_i && !prev_done) begin
        if (block_addr_i != sd_pkg::START_BLOCK + 5) begin
          value_error("spi_block_addr_o", block_addr_i, sd_pkg::START_BLOCK + 5);
        end
        end_test(5);
        if (error_count_i != 2) value_error("error_count_o", error_count_i, 2);
        done_seen = 1'b1;
      end
      prev_done = done_i;
      if (done_seen) idle_cycles++;
      if (idle_cycles == 50) begin
        $display("tests %0d, checks failed %0d, final error count %0d", tests, errors_o,
                 error_count_i);
        finished_o = 1'b1;
      end
    end
  end

  initial begin
    errors_o = 0;
    finished_o = 1'b0;
  end

endmodule

/* tests/tb_clock.sv */
/*
  Testbench clock and reset source. 40 ns clock period; reset is held
  high for 5 cycles and released on a falling edge.
*/
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* tests/tb_top.sv */
/*
  Testbench top. Holds an SD card model with 6 test blocks behind a
  busy-handshake SPI host, an adder UUT with per-block latency, the DUT
  and the checker. Blocks 1 and 3 expect a wrong value, block 5 ends
  the session with a bad signature.
*/
`timescale 1ns/10ps

module tb_top;

  localparam int LIMIT = 6 * 1100 * 4 * 4;

  logic clk, rst;
  sd_pkg::spi_stat_t spi_stat;
  sd_pkg::spi_cmd_t spi_cmd;
  sd_pkg::block_addr_t block_addr;
  logic [7:0] data_in;
  logic end_uut, uut_rst, done;
  autotest_pkg::result_t result;
  autotest_pkg::operand_t operand_a, operand_b;
  autotest_pkg::error_count_t error_count;
  logic [5:0][31:0] sig, op_a, op_b, expected;
  logic [5:0][7:0] latency;
  logic [7:0] mem [0:6*512-1];
  logic finished;
  int errors, cycles, seed, busy_cnt, op, blk, idx, run_cnt;
  logic in_blk;
  logic [7:0] wdata;

  tb_clock clk0 (.clk(clk), .rst(rst));

  autotest_top dut0 (
    .clk(clk), .rst(rst), .spi_stat_i(spi_stat), .end_uut_i(end_uut), .result_i(result),
    .spi_cmd_o(spi_cmd), .spi_block_addr_o(block_addr), .spi_data_in_o(data_in),
    .uut_rst_o(uut_rst), .operand_a_o(operand_a), .operand_b_o(operand_b),
    .error_count_o(error_count), .done_o(done)
  );

  tb_checker chk0 (
    .clk(clk), .rst(rst), .spi_cmd_i(spi_cmd), .spi_stat_i(spi_stat),
    .block_addr_i(block_addr), .data_in_i(data_in), .uut_rst_i(uut_rst),
    .operand_a_i(operand_a), .operand_b_i(operand_b), .error_count_i(error_count),
    .done_i(done), .op_a_i(op_a), .op_b_i(op_b), .expected_i(expected),
    .latency_i(latency), .finished_o(finished), .errors_o(errors)
  );

  // fill depends on block and byte position
  function automatic logic [7:0] fill(input int b, input int i);
    int a;
    a = b * 512 + i;
    return 8'(a ^ (a >> 8) ^ (a >> 3));
  endfunction

  task automatic start_op(input int kind);
    op = kind;
    spi_stat.busy = 1'b1;
    busy_cnt = 1 + ($random(seed) & 3);
  endtask

  // SD card behind the SPI host; op 0 reset, 1 open, 2 read, 3 write
  always @(negedge clk) begin
    blk = int'(block_addr - sd_pkg::START_BLOCK);
    if (rst) begin
      spi_stat = '0;
      busy_cnt = 0;
      in_blk = 1'b0;
    end else if (busy_cnt > 0) begin
      busy_cnt--;
      if (busy_cnt == 0) begin
        spi_stat.busy = 1'b0;
        if (op == 2) begin
          spi_stat.data_out = mem[blk * 512 + idx];
          idx++;
        end else if (op == 3) begin
          mem[blk * 512 + idx] = wdata;
          idx++;
        end
      end
    end else begin
      if (!spi_cmd.r_block && !spi_cmd.w_block) in_blk = 1'b0;
      if (spi_cmd.rst) begin
        start_op(0);
      end else if (spi_cmd.r_byte) begin
        start_op(2);
      end else if (spi_cmd.w_byte) begin
        wdata = data_in;
        start_op(3);
      end else if ((spi_cmd.r_block || spi_cmd.w_block) && !in_blk) begin
        in_blk = 1'b1;
        idx = 0;
        start_op(1);
      end
    end
  end

  // adder UUT, ends after the block's latency
  always @(negedge clk) begin
    result = operand_a + operand_b;
    if (rst || uut_rst) begin
      run_cnt = 0;
      end_uut = 1'b0;
    end else if (run_cnt == latency[blk]) begin
      end_uut = 1'b1;
    end else begin
      run_cnt++;
    end
  end

  always @(posedge clk) cycles++;

  initial begin
    seed = 55571;
    cycles = 0;
    spi_stat = '0;
    end_uut = 1'b0;
    result = '0;
    op_a = {32'h0, 32'h0F0F0F0F, 32'hDEADBEEF, 32'hFFFFFFFF, 32'h5, 32'h12345678};
    op_b = {32'h0, 32'hF0F0F0F0, 32'h01010101, 32'h2, 32'h7, 32'h11111111};
    expected = {32'h0, 32'hFFFFFFFF, 32'h0, 32'h1, 32'hD, 32'h23456789};
    latency = {8'd2, 8'd5, 8'd12, 8'd1, 8'd7, 8'd3};
    sig = {32'h12345678, {5{autotest_pkg::SIGNATURE}}};
    for (int b = 0; b < 6; b++) begin
      for (int i = 0; i < 512; i++) begin
        if (i < 4) mem[b * 512 + i] = 8'(sig[b] >> (8 * (3 - i)));
        else if (i < 8) mem[b * 512 + i] = 8'(op_a[b] >> (8 * (i - 4)));
        else if (i < 12) mem[b * 512 + i] = 8'(op_b[b] >> (8 * (i - 8)));
        else if (i < 16) mem[b * 512 + i] = 8'(expected[b] >> (8 * (i - 12)));
        else mem[b * 512 + i] = fill(b, i);
      end
    end
    while (!finished && cycles < LIMIT) @(posedge clk);
    if (finished && errors == 0 && dut0.sva0.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      if (!finished) $display("timeout: session did not finish within %0d cycles", LIMIT);
      $display("Test failed");
    end
    $finish;
  end

endmodule
